// ==== dcache_config.svh ====
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// ======================================================================
// Geometry of the data cache
// ======================================================================

// The processor issues word addresses, so two low byte bits never appear
`define DC_ADDR_W 30

// One line holds exactly one data word
`define DC_DATA_W 32

// Four ways per set
`define DC_WAYS 4

// Seven index bits give 128 sets
`define DC_NDX_W 7

// The tag is whatever is left of the word address above the index
`define DC_TAG_W (`DC_ADDR_W - `DC_NDX_W)

`endif

// ==== dcache_pkg.sv ====
`default_nettype none

`include "dcache_config.svh"

package dcache_pkg;

  // Operations a processor request can carry
  typedef enum logic [1:0] {
    DC_READ  = 2'd0,
    DC_WRITE = 2'd1,
    DC_INVAL = 2'd2
  } dc_op_e;

  // Controller states, in the order a miss walks through them
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    DECIDE,
    MEM_REQ,
    MEM_WAIT,
    FILL,
    DONE
  } dc_state_e;

  // Processor request payload, held stable while req is high
  typedef struct packed {
    dc_op_e                 op;
    logic [`DC_ADDR_W-1:0]  addr;
    logic [`DC_DATA_W-1:0]  wdata;
  } cpu_req_t;

  // Memory request payload; we low means a read of one word
  typedef struct packed {
    logic                   we;
    logic [`DC_ADDR_W-1:0]  addr;
    logic [`DC_DATA_W-1:0]  wdata;
  } mem_req_t;

  // Way number inside a set
  typedef logic [1:0] way_t;

endpackage

`default_nettype wire

// ==== dcache_tag_store.sv ====
`default_nettype none

`include "dcache_config.svh"

module dcache_tag_store (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic [`DC_NDX_W-1:0]   ndx,
  input  wire logic                   tag_wr,
  input  wire logic                   inval,
  input  wire dcache_pkg::way_t       wr_way,
  input  wire logic [`DC_TAG_W-1:0]   wr_tag,
  output logic      [`DC_TAG_W-1:0]   tags [`DC_WAYS],
  output logic      [`DC_WAYS-1:0]    valid
);

  localparam int SETS = 1 << `DC_NDX_W;

  // ======================================================================
  // Storage
  // ======================================================================

  // Tag words, one array per way, indexed by set
  logic [`DC_TAG_W-1:0] tag_mem [`DC_WAYS][SETS];

  // Valid bits live in flops so reset can wipe the whole cache at once
  logic [SETS-1:0] valid_q [`DC_WAYS];

  // ======================================================================
  // Writes
  // ======================================================================

  // A fill writes the tag of the victim way in the addressed set
  always_ff @(posedge clk)
  begin
    if (tag_wr)
    begin
      tag_mem[wr_way][ndx] <= wr_tag;
    end
  end

  // A fill marks the line valid; an invalidate clears it
  // Fill wins if both strobes were ever raised together
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int w = 0; w < `DC_WAYS; w++)
      begin
        valid_q[w] <= '0;
      end
    end
    else if (tag_wr)
    begin
      valid_q[wr_way][ndx] <= 1'b1;
    end
    else if (inval)
    begin
      valid_q[wr_way][ndx] <= 1'b0;
    end
  end

  // ======================================================================
  // Reads
  // ======================================================================

  // All four ways of the addressed set are read in parallel
  // The hit detector compares them in the same cycle
  always_comb
  begin
    for (int w = 0; w < `DC_WAYS; w++)
    begin
      tags[w]  = tag_mem[w][ndx];
      valid[w] = valid_q[w][ndx];
    end
  end

endmodule

`default_nettype wire

// ==== dcache_hit.sv ====
`default_nettype none

`include "dcache_config.svh"

module dcache_hit (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic [`DC_TAG_W-1:0]   tags [`DC_WAYS],
  input  wire logic [`DC_WAYS-1:0]    valid,
  input  wire logic [`DC_TAG_W-1:0]   req_tag,
  output logic      [`DC_WAYS-1:0]    hits,
  output logic                        hit,
  output dcache_pkg::way_t            rway
);

  import dcache_pkg::*;

  // Way picked from this cycle's compare, before it is registered
  way_t sel_way;

  // ======================================================================
  // Tag compare
  // ======================================================================

  // A way hits when its stored tag matches and the line is valid
  always_comb
  begin
    for (int w = 0; w < `DC_WAYS; w++)
    begin
      hits[w] = (tags[w] == req_tag) && valid[w];
    end
  end

  // Priority encode, lowest way first
  // The loop runs downwards so the lowest hitting way is assigned last
  // With no hit the way from the previous lookup stays selected
  always_comb
  begin
    sel_way = rway;
    for (int w = `DC_WAYS - 1; w >= 0; w--)
    begin
      if (hits[w])
      begin
        sel_way = way_t'(w);
      end
    end
  end

  // ======================================================================
  // Result registers
  // ======================================================================

  // Hit flag and way are sampled at the end of the lookup cycle
  // The controller reads them one cycle later
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      hit  <= 1'b0;
      rway <= '0;
    end
    else
    begin
      hit  <= |hits;
      rway <= sel_way;
    end
  end

endmodule

`default_nettype wire

// ==== dcache_data_store.sv ====
`default_nettype none

`include "dcache_config.svh"

module dcache_data_store (
  input  wire logic                   clk,
  input  wire logic [`DC_NDX_W-1:0]   ndx,
  input  wire dcache_pkg::way_t       rd_way,
  input  wire logic                   wr,
  input  wire dcache_pkg::way_t       wr_way,
  input  wire logic [`DC_DATA_W-1:0]  wr_data,
  output logic      [`DC_DATA_W-1:0]  rd_data
);

  localparam int SETS = 1 << `DC_NDX_W;

  // ======================================================================
  // Line storage
  // ======================================================================

  // One word per line, an array per way, indexed by set
  logic [`DC_DATA_W-1:0] data_mem [`DC_WAYS][SETS];

  // Written by a fill into the victim way, or by a write hit into the
  // way that hit
  always_ff @(posedge clk)
  begin
    if (wr)
    begin
      data_mem[wr_way][ndx] <= wr_data;
    end
  end

  // ======================================================================
  // Read port
  // ======================================================================

  // Way multiplexer on the addressed set
  // The select comes from the registered hit way, so the word is ready
  // in the cycle the controller decides
  always_comb
  begin
    rd_data = data_mem[rd_way][ndx];
  end

endmodule

`default_nettype wire

// ==== dcache_ctrl.sv ====
`default_nettype none

`include "dcache_config.svh"

module dcache_ctrl (
  input  wire logic                   clk,
  input  wire logic                   rst,
  // Processor port
  input  wire dcache_pkg::cpu_req_t   cpu_req,
  input  wire logic                   cpu_req_valid,
  output logic                        cpu_ack,
  output logic      [`DC_DATA_W-1:0]  cpu_rdata,
  // Memory port
  output dcache_pkg::mem_req_t        mem_req,
  output logic                        mem_req_valid,
  input  wire logic                   mem_ack,
  input  wire logic [`DC_DATA_W-1:0]  mem_rdata,
  // Lookup
  output logic      [`DC_NDX_W-1:0]   ndx,
  output logic      [`DC_TAG_W-1:0]   req_tag,
  input  wire logic                   hit,
  input  wire dcache_pkg::way_t       rway,
  input  wire logic [`DC_DATA_W-1:0]  store_rdata,
  // Store updates
  output logic                        tag_wr,
  output logic                        inval,
  output logic                        data_wr,
  output dcache_pkg::way_t            wr_way,
  output logic      [`DC_DATA_W-1:0]  wr_data
);

  import dcache_pkg::*;

  dc_state_e             state_q;
  cpu_req_t              req_q;
  logic [`DC_DATA_W-1:0] fill_q;
  // Round-robin victim pointer, one for the whole cache
  way_t                  victim_q;

  // ======================================================================
  // Lookup address and store strobes
  // ======================================================================

  // Index is the low bits of the latched word address, tag the rest
  assign ndx     = req_q.addr[`DC_NDX_W-1:0];
  assign req_tag = req_q.addr[`DC_ADDR_W-1:`DC_NDX_W];

  always_comb
  begin
    tag_wr  = (state_q == FILL);
    // Write-through updates the cached copy only when the line is present
    data_wr = tag_wr || (state_q == DECIDE && req_q.op == DC_WRITE && hit);
    inval   = (state_q == DECIDE) && (req_q.op == DC_INVAL) && hit;
    wr_way  = tag_wr ? victim_q : rway;
    wr_data = tag_wr ? fill_q : req_q.wdata;
  end

  // ======================================================================
  // Control FSM
  // ======================================================================

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state_q       <= IDLE;
      cpu_ack       <= 1'b0;
      mem_req_valid <= 1'b0;
      victim_q      <= '0;
    end
    else
    begin
      case (state_q)
        // Ack is low here, so any req seen is a fresh one
        IDLE: if (cpu_req_valid) state_q <= LOOKUP;
        // Tags are compared this cycle and the result registered
        LOOKUP: state_q <= DECIDE;
        DECIDE:
        begin
          if ((req_q.op == DC_READ && !hit) || req_q.op == DC_WRITE)
          begin
            // Read miss or any write needs the memory
            mem_req_valid <= 1'b1;
            state_q       <= MEM_REQ;
          end
          else
          begin
            // Read hit or invalidate finishes without memory traffic
            cpu_ack <= 1'b1;
            state_q <= DONE;
          end
        end
        MEM_REQ:
        begin
          if (mem_ack)
          begin
            mem_req_valid <= 1'b0;
            state_q       <= MEM_WAIT;
          end
        end
        // Finish the memory handshake before touching the stores
        MEM_WAIT:
        begin
          if (!mem_ack)
          begin
            if (mem_req.we)
            begin
              cpu_ack <= 1'b1;
              state_q <= DONE;
            end
            else
            begin
              state_q <= FILL;
            end
          end
        end
        FILL:
        begin
          victim_q <= victim_q + 1'b1;
          cpu_ack  <= 1'b1;
          state_q  <= DONE;
        end
        // Hold ack until the processor drops req
        DONE:
        begin
          if (!cpu_req_valid)
          begin
            cpu_ack <= 1'b0;
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // ======================================================================
  // Payload registers
  // ======================================================================

  always_ff @(posedge clk)
  begin
    if (state_q == IDLE && cpu_req_valid)
    begin
      req_q <= cpu_req;
    end
    if (state_q == DECIDE)
    begin
      mem_req.we    <= (req_q.op == DC_WRITE);
      mem_req.addr  <= req_q.addr;
      mem_req.wdata <= req_q.wdata;
    end
    // Read data is only valid while mem_ack is high
    if (state_q == MEM_REQ && mem_ack)
    begin
      fill_q <= mem_rdata;
    end
    if (state_q == DECIDE && req_q.op == DC_READ && hit)
    begin
      cpu_rdata <= store_rdata;
    end
    else if (state_q == FILL)
    begin
      cpu_rdata <= fill_q;
    end
  end

endmodule

`default_nettype wire

// ==== dcache_top.sv ====
`default_nettype none

`include "dcache_config.svh"

module dcache_top (
  input  wire logic                   clk,
  input  wire logic                   rst,
  // Processor load/store port
  input  wire dcache_pkg::cpu_req_t   cpu_req,
  input  wire logic                   cpu_req_valid,
  output logic                        cpu_ack,
  output logic      [`DC_DATA_W-1:0]  cpu_rdata,
  // Word-wide memory port
  output dcache_pkg::mem_req_t        mem_req,
  output logic                        mem_req_valid,
  input  wire logic                   mem_ack,
  input  wire logic [`DC_DATA_W-1:0]  mem_rdata
);

  import dcache_pkg::*;

  // ======================================================================
  // Internal nets
  // ======================================================================

  logic [`DC_NDX_W-1:0]  ndx;
  logic [`DC_TAG_W-1:0]  req_tag;
  logic [`DC_TAG_W-1:0]  tags [`DC_WAYS];
  logic [`DC_WAYS-1:0]   valid;
  logic                  hit;
  way_t                  rway;
  logic [`DC_DATA_W-1:0] store_rdata;
  logic                  tag_wr;
  logic                  inval;
  logic                  data_wr;
  way_t                  wr_way;
  logic [`DC_DATA_W-1:0] wr_data;

  // ======================================================================
  // Blocks
  // ======================================================================

  dcache_tag_store u_tag_store (
    .clk    (clk),
    .rst    (rst),
    .ndx    (ndx),
    .tag_wr (tag_wr),
    .inval  (inval),
    .wr_way (wr_way),
    .wr_tag (req_tag),
    .tags   (tags),
    .valid  (valid)
  );

  // The per-way hit vector is not needed outside the detector
  dcache_hit u_hit (
    .clk     (clk),
    .rst     (rst),
    .tags    (tags),
    .valid   (valid),
    .req_tag (req_tag),
    .hits    (),
    .hit     (hit),
    .rway    (rway)
  );

  // Reads follow the registered hit way
  dcache_data_store u_data_store (
    .clk     (clk),
    .ndx     (ndx),
    .rd_way  (rway),
    .wr      (data_wr),
    .wr_way  (wr_way),
    .wr_data (wr_data),
    .rd_data (store_rdata)
  );

  dcache_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .cpu_req       (cpu_req),
    .cpu_req_valid (cpu_req_valid),
    .cpu_ack       (cpu_ack),
    .cpu_rdata     (cpu_rdata),
    .mem_req       (mem_req),
    .mem_req_valid (mem_req_valid),
    .mem_ack       (mem_ack),
    .mem_rdata     (mem_rdata),
    .ndx           (ndx),
    .req_tag       (req_tag),
    .hit           (hit),
    .rway          (rway),
    .store_rdata   (store_rdata),
    .tag_wr        (tag_wr),
    .inval         (inval),
    .data_wr       (data_wr),
    .wr_way        (wr_way),
    .wr_data       (wr_data)
  );

endmodule

`default_nettype wire

// ==== tb_dcache_checker.sv ====
`default_nettype none

`include "dcache_config.svh"

module tb_dcache_checker (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire dcache_pkg::cpu_req_t   cpu_req,
  input  wire logic                   cpu_req_valid,
  input  wire logic                   cpu_ack,
  input  wire logic [`DC_DATA_W-1:0]  cpu_rdata,
  input  wire dcache_pkg::mem_req_t   mem_req,
  input  wire logic                   mem_req_valid,
  input  wire logic                   mem_ack,
  output int                          test_count,
  output int                          error_count
);

  timeunit 1ns;
  timeprecision 100ps;

  import dcache_pkg::*;

  localparam int SETS = 1 << `DC_NDX_W;

  // ======================================================================
  // Reference state
  // ======================================================================

  // Written words of the memory as the processor should see them
  logic [`DC_DATA_W-1:0] ref_mem [logic [`DC_ADDR_W-1:0]];
  // Which line sits in which way under the replacement rules
  logic [`DC_TAG_W-1:0]  ref_tag [`DC_WAYS][SETS];
  logic                  ref_valid [`DC_WAYS][SETS];
  int                    victim;
  // Request in flight and the memory traffic it caused
  cpu_req_t              cur;
  mem_req_t              txn;
  int                    txn_count;
  logic                  busy;
  logic                  req_q;
  logic                  ack_q;
  logic                  mreq_q;

  initial
  begin
    test_count  = 0;
    error_count = 0;
  end

  function automatic logic [`DC_DATA_W-1:0] initial_word(logic [`DC_ADDR_W-1:0] a);
    return {a[15:0], a[`DC_ADDR_W-1:`DC_ADDR_W-16]} ^ (32'(a) * 32'h9e37_79b1) ^ 32'h5a3c_96e1;
  endfunction

  task automatic value_error(input string msg);
    error_count++;
    $display("ERR at %0d ns: %s", $time, msg);
  endtask

  task automatic protocol_error(input string msg);
    error_count++;
    $display("Handshake problem at %0d ns: %s", $time, msg);
  endtask

  // Coming out of reset both handshake outputs must be low
  always @(negedge rst)
  begin
    if (cpu_ack !== 1'b0 || mem_req_valid !== 1'b0)
      value_error($sformatf("after reset cpu_ack is %b and mem_req_valid is %b",
                            cpu_ack, mem_req_valid));
  end

  // ======================================================================
  // Comparison of one finished request
  // ======================================================================

  task automatic finish_request();
    logic [`DC_NDX_W-1:0]  ndx;
    logic [`DC_TAG_W-1:0]  tag;
    logic [`DC_DATA_W-1:0] expect_data;
    logic                  hit;
    int                    way;
    int                    errs_before;
    ndx         = cur.addr[`DC_NDX_W-1:0];
    tag         = cur.addr[`DC_ADDR_W-1:`DC_NDX_W];
    hit         = 1'b0;
    way         = 0;
    errs_before = error_count;
    // The search stops at the lowest way whose valid line holds the tag
    for (int w = 0; w < `DC_WAYS; w++)
    begin
      if (!hit && ref_valid[w][ndx] && ref_tag[w][ndx] == tag)
      begin
        hit = 1'b1;
        way = w;
      end
    end
    case (cur.op)
      DC_READ:
      begin
        expect_data = ref_mem.exists(cur.addr) ? ref_mem[cur.addr] : initial_word(cur.addr);
        if (cpu_rdata !== expect_data)
          value_error($sformatf("read of %h returned %h, expected %h",
                                cur.addr, cpu_rdata, expect_data));
        if (hit && txn_count != 0)
          value_error($sformatf("read hit on %h made %0d memory transactions",
                                cur.addr, txn_count));
        if (!hit)
        begin
          if (txn_count != 1 || txn.we || txn.addr != cur.addr)
            value_error($sformatf("read miss on %h made %0d transactions (we %b addr %h)",
                                  cur.addr, txn_count, txn.we, txn.addr));
          // Miss fills the shared round-robin victim
          ref_tag[victim][ndx]   = tag;
          ref_valid[victim][ndx] = 1'b1;
          victim                 = (victim + 1) % `DC_WAYS;
        end
      end
      DC_WRITE:
      begin
        if (txn_count != 1 || !txn.we || txn.addr != cur.addr || txn.wdata != cur.wdata)
          value_error($sformatf("write %h to %h made %0d transactions (we %b addr %h data %h)",
                                cur.wdata, cur.addr, txn_count, txn.we, txn.addr, txn.wdata));
        // Write-through with no allocate leaves the cache lines where they are
        ref_mem[cur.addr] = cur.wdata;
      end
      default:
      begin
        if (txn_count != 0)
          value_error($sformatf("invalidate of %h made %0d memory transactions",
                                cur.addr, txn_count));
        if (hit)
          ref_valid[way][ndx] = 1'b0;
      end
    endcase
    test_count++;
    $display("Test %0d: %s %h %s %s", test_count, cur.op.name(), cur.addr,
             hit ? "hit" : "miss", (error_count == errs_before) ? "pass" : "FAIL");
    busy = 1'b0;
  endtask

  // ======================================================================
  // Port monitor
  // ======================================================================

  // Ports are sampled on the rising edge half a cycle after the testbench drives them
  always @(posedge clk)
  begin
    if (rst)
    begin
      for (int w = 0; w < `DC_WAYS; w++)
        for (int s = 0; s < SETS; s++)
          ref_valid[w][s] = 1'b0;
      victim    = 0;
      busy      = 1'b0;
      txn_count = 0;
      req_q     = 1'b0;
      ack_q     = 1'b0;
      mreq_q    = 1'b0;
    end
    else
    begin
      if (cpu_req_valid && !req_q)
      begin
        cur       = cpu_req;
        busy      = 1'b1;
        txn_count = 0;
      end
      if (mem_req_valid && !mreq_q)
      begin
        if (!busy)
          protocol_error("memory request raised with no processor request in flight");
        if (mem_ack)
          protocol_error("memory request raised before the previous ack fell");
        txn = mem_req;
        txn_count++;
      end
      if (cpu_ack && !ack_q)
      begin
        if (!busy)
          protocol_error("processor ack raised with no request in flight");
        else
          finish_request();
      end
      req_q  = cpu_req_valid;
      ack_q  = cpu_ack;
      mreq_q = mem_req_valid;
    end
  end

endmodule

`default_nettype wire

// ==== tb_dcache.sv ====
`default_nettype none

`include "dcache_config.svh"

module tb_dcache;

  timeunit 1ns;
  timeprecision 100ps;

  import dcache_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  localparam int DIRECTED_OPS = 15;
  localparam int RANDOM_OPS   = 400;
  localparam int TOTAL_OPS    = DIRECTED_OPS + RANDOM_OPS;
  // Twenty clocks per operation, plus reset and the final drain
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_OPS * 20 + 16;
  localparam int TAG_W = `DC_TAG_W;
  localparam int NDX_W = `DC_NDX_W;

  logic                  clk;
  logic                  rst;
  cpu_req_t              cpu_req;
  logic                  cpu_req_valid;
  logic                  cpu_ack;
  logic [`DC_DATA_W-1:0] cpu_rdata;
  mem_req_t              mem_req;
  logic                  mem_req_valid;
  logic                  mem_ack;
  logic [`DC_DATA_W-1:0] mem_rdata;
  int                    test_count;
  int                    error_count;
  int                    ops_issued;

  // Sparse backing memory, only words that were written are stored
  logic [`DC_DATA_W-1:0] mem_arr [logic [`DC_ADDR_W-1:0]];
  // Memory ack delays, drawn from the seeded stream before any traffic
  int                    delay_tab [64];
  int                    delay_idx;
  // Only three sets are used so that lines collide and get evicted often
  int                    set_pool [3] = '{17, 34, 127};

  dcache_top uut (
    .clk           (clk),
    .rst           (rst),
    .cpu_req       (cpu_req),
    .cpu_req_valid (cpu_req_valid),
    .cpu_ack       (cpu_ack),
    .cpu_rdata     (cpu_rdata),
    .mem_req       (mem_req),
    .mem_req_valid (mem_req_valid),
    .mem_ack       (mem_ack),
    .mem_rdata     (mem_rdata)
  );

  tb_dcache_checker checker_inst (
    .clk           (clk),
    .rst           (rst),
    .cpu_req       (cpu_req),
    .cpu_req_valid (cpu_req_valid),
    .cpu_ack       (cpu_ack),
    .cpu_rdata     (cpu_rdata),
    .mem_req       (mem_req),
    .mem_req_valid (mem_req_valid),
    .mem_ack       (mem_ack),
    .test_count    (test_count),
    .error_count   (error_count)
  );

  // Contents of a memory word that was never written, spread over the whole address
  function automatic logic [`DC_DATA_W-1:0] backing_word(logic [`DC_ADDR_W-1:0] a);
    return {a[15:0], a[`DC_ADDR_W-1:`DC_ADDR_W-16]} ^ (32'(a) * 32'h9e37_79b1) ^ 32'h5a3c_96e1;
  endfunction

  // Word address built from a tag number and a set number
  function automatic logic [`DC_ADDR_W-1:0] word_addr(int t, int s);
    return {TAG_W'(t * 32'h1357 + 1), NDX_W'(s)};
  endfunction

  // One full four-phase transaction on the processor port, entered on a falling edge
  task automatic issue_request(input dc_op_e op, input logic [`DC_ADDR_W-1:0] addr,
                               input logic [`DC_DATA_W-1:0] wdata);
    cpu_req.op    = op;
    cpu_req.addr  = addr;
    cpu_req.wdata = wdata;
    cpu_req_valid = 1'b1;
    do @(negedge clk); while (!cpu_ack);
    cpu_req_valid = 1'b0;
    do @(negedge clk); while (cpu_ack);
    ops_issued++;
  endtask

  // ======================================================================
  // Clock and watchdog
  // ======================================================================

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run went %0d clock cycles without finishing", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  // ======================================================================
  // Memory responder
  // ======================================================================

  // Acks one to five cycles after it sees a request, drops ack once req falls
  initial
  begin
    mem_ack   = 1'b0;
    mem_rdata = '0;
    delay_idx = 0;
    forever
    begin
      @(negedge clk);
      if (mem_req_valid && !mem_ack)
      begin
        repeat (delay_tab[delay_idx % 64]) @(negedge clk);
        delay_idx++;
        if (mem_req.we)
          mem_arr[mem_req.addr] = mem_req.wdata;
        else if (mem_arr.exists(mem_req.addr))
          mem_rdata = mem_arr[mem_req.addr];
        else
          mem_rdata = backing_word(mem_req.addr);
        mem_ack = 1'b1;
        do @(negedge clk); while (mem_req_valid);
        mem_ack = 1'b0;
      end
    end
  end

  // ======================================================================
  // Processor stimulus
  // ======================================================================

  initial
  begin
    dc_op_e                op;
    logic [`DC_ADDR_W-1:0] addr;
    logic [`DC_DATA_W-1:0] wdata;
    int                    r;
    void'($urandom(97));
    rst           = 1'b1;
    cpu_req       = '0;
    cpu_req_valid = 1'b0;
    ops_issued    = 0;
    for (int i = 0; i < 64; i++)
      delay_tab[i] = $urandom_range(1, 5);
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    // Five tags into set 17 fill ways 0 to 3 and then wrap to way 0
    for (int t = 0; t < 5; t++)
      issue_request(DC_READ, word_addr(t, 17), '0);
    // Tag 0 was the first victim of the wrap, so it misses again
    issue_request(DC_READ, word_addr(0, 17), '0);
    // Write hit on tag 2, the line must then return the new word
    issue_request(DC_WRITE, word_addr(2, 17), 32'hcafe_0002);
    issue_request(DC_READ, word_addr(2, 17), '0);
    // The refill of tag 0 evicted tag 1, so this write goes around the cache
    issue_request(DC_WRITE, word_addr(1, 17), 32'hbeef_0001);
    issue_request(DC_READ, word_addr(1, 17), '0);
    // Miss, hit, invalidate, miss again, then invalidate a line that is absent
    issue_request(DC_READ, word_addr(0, 34), '0);
    issue_request(DC_READ, word_addr(0, 34), '0);
    issue_request(DC_INVAL, word_addr(0, 34), '0);
    issue_request(DC_READ, word_addr(0, 34), '0);
    issue_request(DC_INVAL, word_addr(5, 34), '0);

    // Random mix, half reads, a third writes, the rest invalidates
    for (int i = 0; i < RANDOM_OPS; i++)
    begin
      r = $urandom_range(0, 99);
      if (r < 50)
        op = DC_READ;
      else if (r < 85)
        op = DC_WRITE;
      else
        op = DC_INVAL;
      addr  = word_addr($urandom_range(0, 5), set_pool[$urandom_range(0, 2)]);
      wdata = $urandom;
      issue_request(op, addr, wdata);
    end

    repeat (4) @(negedge clk);
    $display("Summary: %0d tests checked, %0d issued, %0d errors",
             test_count, ops_issued, error_count);
    if (test_count != ops_issued)
      $display("The checker saw %0d finished requests but %0d were issued",
               test_count, ops_issued);
    if (error_count == 0 && test_count == ops_issued)
    begin
      $display("NO ERRORS");
    end
    else
    begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
dcache_pkg.sv
dcache_tag_store.sv
dcache_hit.sv
dcache_data_store.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache_checker.sv
tb_dcache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the data cache testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_dcache -f sources.f -o sim_dcache

./obj_dir/sim_dcache | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi
echo "Simulation finished cleanly"
